// ==== sim.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

// ==== test/rv_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input wire clk,
    input wire reset,
    input wire bus_we_i,
    input wire bus_re_i
);

    // Read and write never share a cycle
    assert property (@(posedge clk) disable iff (!reset)
        !(bus_we_i && bus_re_i))
    else $error("bus_we_o and bus_re_o high together");

    // A load strobes once, the next cycle is the refetch
    assert property (@(posedge clk) disable iff (!reset)
        bus_re_i |=> !bus_re_i)
    else $error("bus_re_o high in two consecutive cycles");

    // Strobes stay quiet in reset
    assert property (@(posedge clk)
        !reset |-> (!bus_we_i && !bus_re_i))
    else $error("bus strobe high during reset");

endmodule

// Attach to every core instance
bind rv_core rv_core_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .bus_we_i (bus_we_o),
    .bus_re_i (bus_re_o)
);

`default_nettype wire

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb import rv_pkg::*; ();

    // Upper bound on instructions over all programs
    localparam int TOTAL_INSTR = 300;

    logic   clk;
    logic   reset;
    instr_t instr_i;
    xlen_t  pc_o;
    xlen_t  bus_addr_o;
    xlen_t  bus_wdata_o;
    logic   bus_we_o;
    logic   bus_re_o;
    xlen_t  bus_rdata_i;

    instr_t prog[$];
    int     prog_gen;
    xlen_t  pre_mem[xlen_t];
    xlen_t  dmem[xlen_t];
    xlen_t  ref_mem[xlen_t];
    xlen_t  exp_addr_q[$];
    xlen_t  exp_data_q[$];
    xlen_t  obs_addr_q[$];
    xlen_t  obs_data_q[$];
    int     exp_reads;
    int     obs_reads;
    logic [31:0] seed;
    int     errors;
    int     checks;
    int     tests;

    rv_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_i     (instr_i),
        .pc_o        (pc_o),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o),
        .bus_we_o    (bus_we_o),
        .bus_re_o    (bus_re_o),
        .bus_rdata_i (bus_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Program memory answers NOP outside the loaded image
    always @(pc_o or prog_gen) begin
        if (pc_o >= `RV_RESET_PC && ((pc_o - `RV_RESET_PC) >> 2) < prog.size())
            instr_i = prog[(pc_o - `RV_RESET_PC) >> 2];
        else
            instr_i = `RV_NOP;
    end

    // Read data only while the strobe is up
    always @(bus_re_o or bus_addr_o) begin
        if (bus_re_o && dmem.exists(bus_addr_o))
            bus_rdata_i = dmem[bus_addr_o];
        else
            bus_rdata_i = '0;
    end

    // Bus monitor on the falling edge
    always @(negedge clk) begin
        if (reset && bus_we_o) begin
            dmem[bus_addr_o] = bus_wdata_o;
            obs_addr_q.push_back(bus_addr_o);
            obs_data_q.push_back(bus_wdata_o);
        end
        if (reset && bus_re_o) begin
            obs_reads++;
        end
    end

    // Compare observed stores in order against the reference list
    always @(posedge clk) begin
        while (obs_addr_q.size() > 0) begin
            if (exp_addr_q.size() == 0) begin
                $display("%0t: store to %h that the reference never makes",
                         $time, obs_addr_q[0]);
                errors++;
            end else begin
                check_value("bus_addr_o", exp_addr_q.pop_front(), obs_addr_q[0]);
                check_value("bus_wdata_o", exp_data_q.pop_front(), obs_data_q[0]);
            end
            void'(obs_addr_q.pop_front());
            void'(obs_data_q.pop_front());
        end
    end

    // Watchdog
    initial begin
        repeat (TOTAL_INSTR * 3 + 100) @(posedge clk);
        $display("Timeout, programs did not finish within %0d cycles",
                 TOTAL_INSTR * 3 + 100);
        $display("test failed");
        $finish;
    end

    task automatic check_value(string name, xlen_t exp, xlen_t got);
        checks++;
        if (exp !== got) begin
            $display("[ERROR] %0t %s expected %h observed %h", $time, name, exp, got);
            errors++;
        end
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Assembler
    function automatic instr_t enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                     int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                     int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RV_OPC_OP};
    endfunction

    function automatic instr_t enc_sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], `RV_F3_W, imm[4:0], `RV_OPC_STORE};
    endfunction

    function automatic instr_t enc_beq(int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], `RV_F3_BEQ, imm[4:1], imm[11],
                `RV_OPC_BRANCH};
    endfunction

    function automatic instr_t enc_jal(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OPC_JAL};
    endfunction

    function automatic instr_t enc_u(logic [6:0] opc, int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    // ISA model walks the program until pc leaves it and fills the store list
    function automatic void run_reference();
        xlen_t  x[32];
        xlen_t  pc;
        xlen_t  npc;
        xlen_t  a;
        xlen_t  v;
        instr_t w;
        int     steps;
        logic   wr;
        foreach (x[i]) x[i] = '0;
        pc = `RV_RESET_PC;
        steps = 0;
        while (((pc - `RV_RESET_PC) >> 2) < prog.size() && steps < 1000) begin
            w = prog[(pc - `RV_RESET_PC) >> 2];
            npc = pc + 4;
            wr = 1'b0;
            v = '0;
            // I-immediate off rs1 gives the load and jalr address
            a = x[w[19:15]] + {{52{w[31]}}, w[31:20]};
            case (w[6:0])
                `RV_OPC_LUI: begin
                    wr = 1'b1;
                    v = {{32{w[31]}}, w[31:12], 12'b0};
                end
                `RV_OPC_AUIPC: begin
                    wr = 1'b1;
                    v = pc + {{32{w[31]}}, w[31:12], 12'b0};
                end
                `RV_OPC_OPIMM: begin
                    wr = (w[14:12] == 3'b000) || (w[14:12] == 3'b001 && w[31:26] == 0);
                    v = (w[14:12] == 3'b000) ? a : x[w[19:15]] << w[25:20];
                end
                `RV_OPC_OP: begin
                    if (w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
                        wr = 1'b1;
                        v = x[w[19:15]] + x[w[24:20]];
                    end else if (w[14:12] == 3'b000 && w[31:25] == 7'h20) begin
                        wr = 1'b1;
                        v = x[w[19:15]] - x[w[24:20]];
                    end else if (w[14:12] == 3'b010 && w[31:25] == 7'h00) begin
                        wr = 1'b1;
                        v = ($signed(x[w[19:15]]) < $signed(x[w[24:20]])) ? 1 : 0;
                    end
                end
                `RV_OPC_JAL: begin
                    wr = 1'b1;
                    v = pc + 4;
                    npc = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                `RV_OPC_JALR: begin
                    wr = 1'b1;
                    v = pc + 4;
                    npc = {a[63:1], 1'b0};
                end
                `RV_OPC_BRANCH: begin
                    if (x[w[19:15]] == x[w[24:20]])
                        npc = pc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                `RV_OPC_LOAD: begin
                    v = ref_mem.exists(a) ? ref_mem[a] : '0;
                    wr = 1'b1;
                    exp_reads++;
                    // lw sign-extends the low word and lwu zero-extends it
                    v = (w[14:12] == 3'b010) ? {{32{v[31]}}, v[31:0]} : {32'b0, v[31:0]};
                end
                `RV_OPC_STORE: begin
                    a = x[w[19:15]] + {{52{w[31]}}, w[31:25], w[11:7]};
                    ref_mem[a] = {32'b0, x[w[24:20]][31:0]};
                    exp_addr_q.push_back(a);
                    exp_data_q.push_back({32'b0, x[w[24:20]][31:0]});
                end
                default: ;
            endcase
            if (wr && w[11:7] != 0) x[w[11:7]] = v;
            pc = npc;
            steps++;
        end
    endfunction

    // Resets the core and runs the loaded program until pc is past its end
    task automatic run_prog(string name);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        reset = 1'b0;
        dmem = pre_mem;
        ref_mem = pre_mem;
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_reads = 0;
        obs_reads = 0;
        run_reference();
        prog_gen++;
        repeat (4) @(posedge clk);
        #1 reset = 1'b1;
        check_value("pc_o", `RV_RESET_PC, pc_o);
        while (pc_o < `RV_RESET_PC + 4 * prog.size() + 12) @(posedge clk);
        @(posedge clk);
        #1;
        if (exp_addr_q.size() != 0) begin
            $display("%0t: %0d expected stores never appeared", $time, exp_addr_q.size());
            errors++;
        end
        check_value("bus_re_o strobes", exp_reads, obs_reads);
        tests++;
        $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        int a;
        reset = 1'b0;
        instr_i = `RV_NOP;
        bus_rdata_i = '0;
        seed = 32'hb7c3;
        prog_gen = 0;
        exp_reads = 0;
        obs_reads = 0;
        errors = 0;
        checks = 0;
        tests = 0;

        // ALU ops with each result stored
        prog = '{enc_u(`RV_OPC_LUI, 1, 20'hfedcb), enc_sw(1, 0, 'h100),
                 enc_u(`RV_OPC_AUIPC, 2, 1), enc_sw(2, 0, 'h104),
                 enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 3, 1, -5), enc_sw(3, 0, 'h108),
                 enc_i(`RV_OPC_OPIMM, `RV_F3_SLL, 4, 3, 13), enc_sw(4, 0, 'h10c),
                 enc_r(`RV_F7_BASE, `RV_F3_ADD, 5, 3, 4), enc_sw(5, 0, 'h110),
                 enc_r(`RV_F7_SUB, `RV_F3_ADD, 6, 1, 4), enc_sw(6, 0, 'h114),
                 enc_r(`RV_F7_BASE, `RV_F3_SLT, 7, 6, 5), enc_sw(7, 0, 'h118),
                 enc_r(`RV_F7_BASE, `RV_F3_SLT, 8, 5, 6), enc_sw(8, 0, 'h11c)};
        run_prog("alu");

        // Loads of a word with bit 31 set
        // slt against x0 shows the sign
        pre_mem['h200] = 64'h0000_0000_8765_4321;
        prog = '{enc_i(`RV_OPC_LOAD, `RV_F3_W, 1, 0, 'h200),
                 enc_i(`RV_OPC_LOAD, `RV_F3_WU, 2, 0, 'h200),
                 enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 5, 1, 1),
                 enc_sw(1, 0, 'h300), enc_sw(2, 0, 'h304), enc_sw(5, 0, 'h308),
                 enc_r(`RV_F7_BASE, `RV_F3_SLT, 3, 1, 0),
                 enc_r(`RV_F7_BASE, `RV_F3_SLT, 4, 2, 0),
                 enc_sw(3, 0, 'h30c), enc_sw(4, 0, 'h310)};
        run_prog("load");

        // Shadow slots at 2, 4, 8 and 9 must never store
        prog = '{enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 1, 0, 7), enc_beq(1, 1, 8),
                 enc_sw(1, 0, 'h400), enc_jal(2, 8), enc_sw(1, 0, 'h404),
                 enc_sw(2, 0, 'h408), enc_u(`RV_OPC_AUIPC, 3, 0),
                 enc_i(`RV_OPC_JALR, `RV_F3_JALR, 4, 3, 16),
                 enc_sw(1, 0, 'h40c), enc_sw(1, 0, 'h410), enc_sw(4, 0, 'h414),
                 enc_beq(1, 0, 8), enc_sw(1, 0, 'h418), enc_sw(3, 0, 'h41c)};
        run_prog("branch");

        prog = '{enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 0, 0, 55),
                 enc_u(`RV_OPC_LUI, 0, 1), enc_sw(0, 0, 'h500)};
        run_prog("x0");

        // Random mix over a 16-word data window
        for (int i = 0; i < 16; i++) pre_mem['h600 + 4 * i] = {32'b0, next_rand()};
        prog.delete();
        for (int i = 0; i < 200; i++) begin
            a = 'h600 + 4 * (next_rand() % 16);
            case (next_rand() % 9)
                0: prog.push_back(enc_u(`RV_OPC_LUI, next_rand() % 32, next_rand()));
                1: prog.push_back(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, next_rand() % 32,
                                        next_rand() % 32, next_rand()));
                2: prog.push_back(enc_i(`RV_OPC_OPIMM, `RV_F3_SLL, next_rand() % 32,
                                        next_rand() % 32, next_rand() % 64));
                3: prog.push_back(enc_r(`RV_F7_BASE, `RV_F3_ADD, next_rand() % 32,
                                        next_rand() % 32, next_rand() % 32));
                4: prog.push_back(enc_r(`RV_F7_SUB, `RV_F3_ADD, next_rand() % 32,
                                        next_rand() % 32, next_rand() % 32));
                5: prog.push_back(enc_r(`RV_F7_BASE, `RV_F3_SLT, next_rand() % 32,
                                        next_rand() % 32, next_rand() % 32));
                6: prog.push_back(enc_i(`RV_OPC_LOAD, `RV_F3_W, next_rand() % 32, 0, a));
                7: prog.push_back(enc_i(`RV_OPC_LOAD, `RV_F3_WU, next_rand() % 32, 0, a));
                default: prog.push_back(enc_sw(next_rand() % 32, 0, a));
            endcase
        end
        for (int r = 0; r < 32; r++) prog.push_back(enc_sw(r, 0, 'h700 + 4 * r));
        run_prog("random");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Fetch address after reset
`define RV_RESET_PC     64'h8000_0000
// addi x0, x0, 0
`define RV_NOP          32'h0000_0013

// Major opcodes
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_OPIMM    7'b0010011
`define RV_OPC_OP       7'b0110011
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011

// funct3 codes
`define RV_F3_ADD       3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_JALR      3'b000
`define RV_F3_BEQ       3'b000
`define RV_F3_W         3'b010
`define RV_F3_WU        3'b110

// funct7 codes for register-register ops
`define RV_F7_BASE      7'b0000000
`define RV_F7_SUB       7'b0100000

// Integer register count
`define RV_NREGS        32

`endif

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire    clk,
    input  wire    reset,
    input  instr_t instr_i,
    output xlen_t  pc_o,
    output xlen_t  bus_addr_o,
    output xlen_t  bus_wdata_o,
    output logic   bus_we_o,
    output logic   bus_re_o,
    input  xlen_t  bus_rdata_i
);

    // Decoded fields
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
    xlen_t    ipc;

    // Register read data
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    // Execute results
    xlen_t    alu;
    logic     taken;
    xlen_t    target;
    xlen_t    mem_addr;
    xlen_t    store_data;

    // Writeback port
    logic     rf_we;
    reg_idx_t rf_rd;
    xlen_t    rf_data;

    // Latches the word at pc_o
    rv_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .instr_i (instr_i),
        .pc_i    (pc_o),
        .op_o    (op),
        .rd_o    (rd),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .imm_o   (imm),
        .ipc_o   (ipc)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .rd_data_i  (rf_data)
    );

    rv_execute u_execute (
        .op_i         (op),
        .imm_i        (imm),
        .ipc_i        (ipc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .alu_o        (alu),
        .taken_o      (taken),
        .target_o     (target),
        .mem_addr_o   (mem_addr),
        .store_data_o (store_data)
    );

    // Owns pc, the bus and the write port
    rv_result u_result (
        .clk          (clk),
        .reset        (reset),
        .op_i         (op),
        .rd_i         (rd),
        .alu_i        (alu),
        .target_i     (target),
        .mem_addr_i   (mem_addr),
        .store_data_i (store_data),
        .taken_i      (taken),
        .bus_rdata_i  (bus_rdata_i),
        .pc_o         (pc_o),
        .rf_we_o      (rf_we),
        .rf_rd_o      (rf_rd),
        .rf_data_o    (rf_data),
        .bus_addr_o   (bus_addr_o),
        .bus_wdata_o  (bus_wdata_o),
        .bus_we_o     (bus_we_o),
        .bus_re_o     (bus_re_o)
    );

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_decode import rv_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  instr_t   instr_i,
    input  xlen_t    pc_i,
    output op_e      op_o,
    output reg_idx_t rd_o,
    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output xlen_t    imm_o,
    output xlen_t    ipc_o
);

    instr_t     ir_q;
    xlen_t      ipc_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Instruction register, comes up as a no-op
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir_q <= `RV_NOP;
        end else begin
            ir_q <= instr_i;
        end
    end

    // Address the word was fetched from
    always_ff @(posedge clk) begin
        ipc_q <= pc_i;
    end

    assign opcode = ir_q[6:0];
    assign funct3 = ir_q[14:12];
    assign funct7 = ir_q[31:25];

    // Register fields at fixed positions
    assign rd_o  = ir_q[11:7];
    assign rs1_o = ir_q[19:15];
    assign rs2_o = ir_q[24:20];
    assign ipc_o = ipc_q;

    // Operation decode
    always_comb begin
        op_o = OP_NOP;
        case (opcode)
            `RV_OPC_LUI:   op_o = OP_LUI;
            `RV_OPC_AUIPC: op_o = OP_AUIPC;
            `RV_OPC_OPIMM: begin
                if (funct3 == `RV_F3_ADD) op_o = OP_ADDI;
                // RV64 shamt is 6 bits, upper funct field is 6 zeros
                if (funct3 == `RV_F3_SLL && ir_q[31:26] == 6'b0) op_o = OP_SLLI;
            end
            `RV_OPC_OP: begin
                if (funct3 == `RV_F3_ADD && funct7 == `RV_F7_BASE) op_o = OP_ADD;
                if (funct3 == `RV_F3_ADD && funct7 == `RV_F7_SUB) op_o = OP_SUB;
                if (funct3 == `RV_F3_SLT && funct7 == `RV_F7_BASE) op_o = OP_SLT;
            end
            `RV_OPC_JAL:   op_o = OP_JAL;
            `RV_OPC_JALR:  if (funct3 == `RV_F3_JALR) op_o = OP_JALR;
            `RV_OPC_BRANCH: if (funct3 == `RV_F3_BEQ) op_o = OP_BEQ;
            `RV_OPC_LOAD: begin
                if (funct3 == `RV_F3_W) op_o = OP_LW;
                if (funct3 == `RV_F3_WU) op_o = OP_LWU;
            end
            `RV_OPC_STORE: if (funct3 == `RV_F3_W) op_o = OP_SW;
            default:       op_o = OP_NOP;
        endcase
    end

    // Immediate per format, all sign-extended from bit 31
    always_comb begin
        case (op_o)
            OP_LUI, OP_AUIPC:
                imm_o = {{32{ir_q[31]}}, ir_q[31:12], 12'b0};
            OP_ADDI, OP_JALR, OP_LW, OP_LWU:
                imm_o = {{52{ir_q[31]}}, ir_q[31:20]};
            // Shift amount only
            OP_SLLI:
                imm_o = {58'b0, ir_q[25:20]};
            OP_SW:
                imm_o = {{52{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            OP_JAL:
                imm_o = {{44{ir_q[31]}}, ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
            OP_BEQ:
                imm_o = {{52{ir_q[31]}}, ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  op_e   op_i,
    input  xlen_t imm_i,
    input  xlen_t ipc_i,
    input  xlen_t rs1_data_i,
    input  xlen_t rs2_data_i,
    output xlen_t alu_o,
    output logic  taken_o,
    output xlen_t target_o,
    output xlen_t mem_addr_o,
    output xlen_t store_data_o
);

    xlen_t rs1_plus_imm;
    xlen_t ipc_plus_imm;
    xlen_t link_addr;
    xlen_t sum;
    xlen_t diff;
    xlen_t shifted;
    logic  less;
    logic  equal;

    // Shared adders
    assign rs1_plus_imm = rs1_data_i + imm_i;
    assign ipc_plus_imm = ipc_i + imm_i;
    // Return address for jal and jalr
    assign link_addr    = ipc_i + 64'd4;

    // Register-register arithmetic
    assign sum  = rs1_data_i + rs2_data_i;
    assign diff = rs1_data_i - rs2_data_i;

    // slli uses the low 6 bits of the immediate
    assign shifted = rs1_data_i << imm_i[5:0];

    // Signed compare for slt
    assign less  = $signed(rs1_data_i) < $signed(rs2_data_i);
    // Equality for beq
    assign equal = (rs1_data_i == rs2_data_i);

    // Value written to rd
    always_comb begin
        case (op_i)
            OP_LUI:          alu_o = imm_i;
            OP_AUIPC:        alu_o = ipc_plus_imm;
            OP_ADDI:         alu_o = rs1_plus_imm;
            OP_SLLI:         alu_o = shifted;
            OP_ADD:          alu_o = sum;
            OP_SUB:          alu_o = diff;
            OP_SLT:          alu_o = {63'b0, less};
            OP_JAL, OP_JALR: alu_o = link_addr;
            default:         alu_o = '0;
        endcase
    end

    // Control transfer decision
    always_comb begin
        case (op_i)
            OP_JAL, OP_JALR: taken_o = 1'b1;
            OP_BEQ:          taken_o = equal;
            default:         taken_o = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    // jal and beq are pc-relative
    assign target_o = (op_i == OP_JALR) ? {rs1_plus_imm[63:1], 1'b0} : ipc_plus_imm;

    // Load and store address, imm already in I or S form
    assign mem_addr_o = rs1_plus_imm;

    // Word store, upper half zero
    assign store_data_o = {32'b0, rs2_data_i[31:0]};

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // One register or address value
    typedef logic [63:0] xlen_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // Decoded operations
    // Anything unrecognized maps to OP_NOP
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LUI,
        OP_AUIPC,
        OP_ADDI,
        OP_SLLI,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_LW,
        OP_LWU,
        OP_SW
    } op_e;

    // Control states of the result stage
    // FLUSH drops the shadow instruction after a taken jump
    // LOAD_WAIT takes read data and drops the refetched word
    typedef enum logic [1:0] {
        ST_RUN,
        ST_FLUSH,
        ST_LOAD_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_regfile import rv_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o,
    input  wire      we_i,
    input  reg_idx_t rd_i,
    input  xlen_t    rd_data_i
);

    xlen_t regs_q [`RV_NREGS];

    // Whole file clears on reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            // x0 never takes a write
            if (we_i && rd_i != '0) begin
                regs_q[rd_i] <= rd_data_i;
            end
        end
    end

    // Combinational reads
    // x0 forced to zero on both ports
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// ==== verilog/rv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_result import rv_pkg::*; (
    input  wire      clk,
    input  wire      reset,
    input  op_e      op_i,
    input  reg_idx_t rd_i,
    input  xlen_t    alu_i,
    input  xlen_t    target_i,
    input  xlen_t    mem_addr_i,
    input  xlen_t    store_data_i,
    input  wire      taken_i,
    input  xlen_t    bus_rdata_i,
    output xlen_t    pc_o,
    output logic     rf_we_o,
    output reg_idx_t rf_rd_o,
    output xlen_t    rf_data_o,
    output xlen_t    bus_addr_o,
    output xlen_t    bus_wdata_o,
    output logic     bus_we_o,
    output logic     bus_re_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    xlen_t       pc_q;
    xlen_t       pc_d;
    reg_idx_t    load_rd_q;
    logic        load_signed_q;
    logic        run;
    logic        is_load;
    logic        is_store;
    logic        writes_rd;
    xlen_t       load_data;

    // Only ST_RUN executes the word in the instruction register
    assign run       = (state_q == ST_RUN);
    assign is_load   = (op_i == OP_LW) || (op_i == OP_LWU);
    assign is_store  = (op_i == OP_SW);
    assign writes_rd = op_i inside {OP_LUI, OP_AUIPC, OP_ADDI, OP_SLLI, OP_ADD,
                                    OP_SUB, OP_SLT, OP_JAL, OP_JALR};

    // Next state and next pc
    always_comb begin
        state_d = ST_RUN;
        pc_d    = pc_q + 64'd4;
        if (run && is_load) begin
            // Refetch the follower after the read
            state_d = ST_LOAD_WAIT;
            pc_d    = pc_q;
        end else if (run && taken_i) begin
            state_d = ST_FLUSH;
            pc_d    = target_i;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q  <= ST_RUN;
            pc_q     <= `RV_RESET_PC;
            bus_we_o <= 1'b0;
            bus_re_o <= 1'b0;
        end else begin
            state_q  <= state_d;
            pc_q     <= pc_d;
            // One-cycle strobes in E+1
            bus_we_o <= run && is_store;
            bus_re_o <= run && is_load;
        end
    end

    // Bus payload and the load's destination
    always_ff @(posedge clk) begin
        if (run && (is_load || is_store)) begin
            bus_addr_o <= mem_addr_i;
        end
        if (run && is_store) begin
            bus_wdata_o <= store_data_i;
        end
        if (run && is_load) begin
            load_rd_q     <= rd_i;
            load_signed_q <= (op_i == OP_LW);
        end
    end

    // Word from the bus, lw sign-extends and lwu zero-extends
    assign load_data = load_signed_q ? {{32{bus_rdata_i[31]}}, bus_rdata_i[31:0]}
                                     : {32'b0, bus_rdata_i[31:0]};

    // Writeback port
    always_comb begin
        rf_we_o   = 1'b0;
        rf_rd_o   = rd_i;
        rf_data_o = alu_i;
        case (state_q)
            ST_RUN: rf_we_o = writes_rd;
            ST_LOAD_WAIT: begin
                // Read data returns this cycle
                rf_we_o   = 1'b1;
                rf_rd_o   = load_rd_q;
                rf_data_o = load_data;
            end
            // Shadow slot writes nothing
            default: rf_we_o = 1'b0;
        endcase
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire
